// File: project.f
rtl/board_pkg.sv
rtl/sram_wr_if.sv
rtl/reset_sequencer.sv
rtl/joy_serial_reader.sv
rtl/wb_rom_loader.sv
rtl/sram_arbiter.sv
rtl/sigma_delta_dac.sv
rtl/board_glue_top.sv
testbench/board_glue_checker.sv
testbench/tb_board_glue.sv

// File: rtl/board_glue_top.sv
//------------------------------------------------
// Board glue top
// Reset, joystick, ROM loader, SRAM sharing and
// audio around an external arcade core
//------------------------------------------------
`default_nettype none

module board_glue_top #(
	parameter int RESET_HOLD   = 256,
	parameter int ENA_DIV_LOG2 = 2
) (
	input  logic                           clk_sys,
	input  logic                           pll_lckd,

	// Wishbone classic slave
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  logic [board_pkg::ROM_ADDR_W:0] wb_adr,
	input  board_pkg::rom_data_t           wb_dat_w,
	output board_pkg::rom_data_t           wb_dat_r,
	output logic                           wb_ack,

	// Core side
	input  board_pkg::rom_addr_t           rom_addr,
	output board_pkg::rom_data_t           rom_data,
	output logic                           core_reset_n,
	input  board_pkg::rom_data_t           sound,
	input  logic                           reset_btn,

	// Joystick shift register
	output logic                           joy_clk,
	output logic                           joy_load,
	input  logic                           joy_data,
	output board_pkg::joy_buttons_t        buttons_p1,
	output board_pkg::joy_buttons_t        buttons_p2,

	// External SRAM, data bus split
	output board_pkg::rom_addr_t           sram_addr,
	output board_pkg::rom_data_t           sram_dout,
	input  board_pkg::rom_data_t           sram_din,
	output logic                           sram_dout_oe,
	output logic                           sram_we_n,

	output logic                           audio_out
);

	logic loading;
	logic slow_ena;

	sram_wr_if wr_bus ();

	reset_sequencer #(
		.RESET_HOLD   (RESET_HOLD),
		.ENA_DIV_LOG2 (ENA_DIV_LOG2)
	) reset_sequencer_inst (
		.clk_sys      (clk_sys),
		.pll_lckd     (pll_lckd),
		.reset_btn    (reset_btn),
		.loading      (loading),
		.core_reset_n (core_reset_n),
		.slow_ena     (slow_ena)
	);

	joy_serial_reader joy_serial_reader_inst (
		.clk_sys    (clk_sys),
		.pll_lckd   (pll_lckd),
		.slow_ena   (slow_ena),
		.joy_data   (joy_data),
		.joy_clk    (joy_clk),
		.joy_load   (joy_load),
		.buttons_p1 (buttons_p1),
		.buttons_p2 (buttons_p2)
	);

	wb_rom_loader wb_rom_loader_inst (
		.clk_sys  (clk_sys),
		.pll_lckd (pll_lckd),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.loading  (loading),
		.wr       (wr_bus.loader)
	);

	sram_arbiter sram_arbiter_inst (
		.clk_sys      (clk_sys),
		.pll_lckd     (pll_lckd),
		.rom_addr     (rom_addr),
		.sram_din     (sram_din),
		.rom_data     (rom_data),
		.sram_addr    (sram_addr),
		.sram_dout    (sram_dout),
		.sram_dout_oe (sram_dout_oe),
		.sram_we_n    (sram_we_n),
		.wr           (wr_bus.arbiter)
	);

	sigma_delta_dac sigma_delta_dac_inst (
		.clk_sys   (clk_sys),
		.pll_lckd  (pll_lckd),
		.sound     (sound),
		.audio_out (audio_out)
	);

endmodule

`default_nettype wire

// File: rtl/board_pkg.sv
//------------------------------------------------
// Board glue package
// Shared widths, button bit map and bus types
//------------------------------------------------
`default_nettype none

package board_pkg;

	localparam int ROM_ADDR_W   = 19;	// External SRAM byte address
	localparam int JOY_BITS     = 12;	// Buttons per player
	localparam int CTRL_SEL_BIT = 19;	// Wishbone address bit for control reg

	typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
	typedef logic [7:0]            rom_data_t;
	typedef logic [JOY_BITS-1:0]   joy_buttons_t;	// Active high, one bit per button

	//------------------------------------------------
	// Button positions inside joy_buttons_t
	//------------------------------------------------
	localparam int BTN_UP      = 0;
	localparam int BTN_DOWN    = 1;
	localparam int BTN_LEFT    = 2;
	localparam int BTN_RIGHT   = 3;
	localparam int BTN_FIRE1   = 4;
	localparam int BTN_FIRE2   = 5;
	localparam int BTN_FIRE3   = 6;
	localparam int BTN_FIRE4   = 7;
	localparam int BTN_START   = 8;
	localparam int BTN_COIN    = 9;
	localparam int BTN_SELECT  = 10;
	localparam int BTN_SERVICE = 11;	// Also the first bit shifted in per player

endpackage

`default_nettype wire

// File: rtl/joy_serial_reader.sv
//------------------------------------------------
// Serial joystick reader
// Latches the external shift register and clocks
// in two 12-button player words
//------------------------------------------------
`default_nettype none

module joy_serial_reader (
	input  logic                    clk_sys,
	input  logic                    pll_lckd,
	input  logic                    slow_ena,
	input  logic                    joy_data,
	output logic                    joy_clk,
	output logic                    joy_load,
	output board_pkg::joy_buttons_t buttons_p1,
	output board_pkg::joy_buttons_t buttons_p2
);

	localparam int FRAME_BITS = 2 * board_pkg::JOY_BITS;
	localparam int BIT_W      = $clog2(FRAME_BITS);

	localparam logic [1:0] ST_IDLE   = 2'd0;	// Pull load low
	localparam logic [1:0] ST_LATCH  = 2'd1;	// Release load
	localparam logic [1:0] ST_SAMPLE = 2'd2;	// Take a bit, raise joy_clk
	localparam logic [1:0] ST_CLK_HI = 2'd3;	// Lower joy_clk

	logic [1:0]            state;
	logic [BIT_W-1:0]      bit_cnt;
	logic [FRAME_BITS-1:0] shift_q;

	always_ff @(posedge clk_sys or negedge pll_lckd) begin
		if (!pll_lckd) begin
			state      <= ST_IDLE;
			bit_cnt    <= '0;
			joy_load   <= 1'b1;
			joy_clk    <= 1'b0;
			buttons_p1 <= '0;
			buttons_p2 <= '0;
		end else if (slow_ena) begin
			case (state)
				ST_IDLE: begin
					joy_load <= 1'b0;
					state    <= ST_LATCH;
				end
				ST_LATCH: begin
					joy_load <= 1'b1;
					bit_cnt  <= '0;
					state    <= ST_SAMPLE;
				end
				ST_SAMPLE: begin
					joy_clk <= 1'b1;
					state   <= ST_CLK_HI;
				end
				default: begin
					joy_clk <= 1'b0;
					if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
						// Frame complete, buttons are active low on the wire
						buttons_p1 <= ~shift_q[FRAME_BITS-1 -: board_pkg::JOY_BITS];
						buttons_p2 <= ~shift_q[board_pkg::JOY_BITS-1:0];
						state      <= ST_IDLE;
					end else begin
						bit_cnt <= bit_cnt + BIT_W'(1);
						state   <= ST_SAMPLE;
					end
				end
			endcase
		end
	end

	// Sampled just before the rising joy_clk edge
	always_ff @(posedge clk_sys) begin
		if (slow_ena && state == ST_SAMPLE)
			shift_q <= {shift_q[FRAME_BITS-2:0], joy_data};
	end

endmodule

`default_nettype wire

// File: rtl/reset_sequencer.sv
//------------------------------------------------
// Reset sequencer
// Power-on hold after PLL lock, core reset
// and the slow clock enable
//------------------------------------------------
`default_nettype none

module reset_sequencer #(
	parameter int RESET_HOLD   = 256,
	parameter int ENA_DIV_LOG2 = 2
) (
	input  logic clk_sys,
	input  logic pll_lckd,
	input  logic reset_btn,
	input  logic loading,
	output logic core_reset_n,
	output logic slow_ena
);

	localparam int HOLD_W = $clog2(RESET_HOLD + 1);
	localparam int CNT_W  = (HOLD_W > ENA_DIV_LOG2) ? HOLD_W : ENA_DIV_LOG2;

	logic [CNT_W-1:0] cnt;	// Free running, wraps
	logic             por_hold;

	always_ff @(posedge clk_sys or negedge pll_lckd) begin
		if (!pll_lckd) begin
			cnt          <= '0;
			por_hold     <= 1'b1;
			core_reset_n <= 1'b0;
		end else begin
			cnt <= cnt + CNT_W'(1);
			// Drop the hold on edge RESET_HOLD so the core leaves reset one edge later
			if (cnt == CNT_W'(RESET_HOLD - 1))
				por_hold <= 1'b0;
			core_reset_n <= ~(por_hold | reset_btn | loading);
		end
	end

	// One pulse per 2**ENA_DIV_LOG2 cycles
	assign slow_ena = &cnt[ENA_DIV_LOG2-1:0];

endmodule

`default_nettype wire

// File: rtl/sigma_delta_dac.sv
//------------------------------------------------
// First-order sigma-delta DAC
// 8-bit sound byte to a 1-bit stream
//------------------------------------------------
`default_nettype none

module sigma_delta_dac (
	input  logic                 clk_sys,
	input  logic                 pll_lckd,
	input  board_pkg::rom_data_t sound,
	output logic                 audio_out
);

	logic [8:0] acc;	// Bit 8 is the carry of the last add

	always_ff @(posedge clk_sys or negedge pll_lckd) begin
		if (!pll_lckd)
			acc <= '0;
		else
			acc <= {1'b0, acc[7:0]} + {1'b0, sound};
	end

	// N carries every 256 cycles for a steady input N
	assign audio_out = acc[8];

endmodule

`default_nettype wire

// File: rtl/sram_arbiter.sv
//------------------------------------------------
// SRAM arbiter
// Loader writes win over core ROM reads
//------------------------------------------------
`default_nettype none

module sram_arbiter (
	input  logic                 clk_sys,
	input  logic                 pll_lckd,
	input  board_pkg::rom_addr_t rom_addr,
	input  board_pkg::rom_data_t sram_din,
	output board_pkg::rom_data_t rom_data,
	output board_pkg::rom_addr_t sram_addr,
	output board_pkg::rom_data_t sram_dout,
	output logic                 sram_dout_oe,
	output logic                 sram_we_n,
	sram_wr_if.arbiter           wr
);

	logic wr_done_q;
	logic wr_active;

	// Request stays up through the done cycle, so mask that one
	assign wr_active = wr.wr_req & ~wr_done_q;

	always_ff @(posedge clk_sys or negedge pll_lckd) begin
		if (!pll_lckd)
			wr_done_q <= 1'b0;
		else
			wr_done_q <= wr_active;
	end

	assign wr.wr_done = wr_done_q;

	//------------------------------------------------
	// SRAM pins and core read path
	//------------------------------------------------
	assign sram_addr    = wr_active ? wr.wr_addr : rom_addr;
	assign sram_dout    = wr.wr_data;
	assign sram_dout_oe = wr_active;
	assign sram_we_n    = ~wr_active;
	assign rom_data     = wr_active ? '0 : sram_din;	// No stale byte to the core

endmodule

`default_nettype wire

// File: rtl/sram_wr_if.sv
//------------------------------------------------
// SRAM write request bus
// Loader to arbiter, held until wr_done
//------------------------------------------------
`default_nettype none

interface sram_wr_if;

	logic                  wr_req;
	board_pkg::rom_addr_t  wr_addr;
	board_pkg::rom_data_t  wr_data;
	logic                  wr_done;	// One cycle pulse

	modport loader  (output wr_req, output wr_addr, output wr_data, input wr_done);
	modport arbiter (input wr_req, input wr_addr, input wr_data, output wr_done);

endinterface

`default_nettype wire

// File: rtl/wb_rom_loader.sv
//------------------------------------------------
// ROM loader, Wishbone classic slave
// SRAM byte writes and the loading flag
//------------------------------------------------
`default_nettype none

module wb_rom_loader (
	input  logic                           clk_sys,
	input  logic                           pll_lckd,
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  logic [board_pkg::ROM_ADDR_W:0] wb_adr,
	input  board_pkg::rom_data_t           wb_dat_w,
	output board_pkg::rom_data_t           wb_dat_r,
	output logic                           wb_ack,
	output logic                           loading,
	sram_wr_if.loader                      wr
);

	logic ctrl_ack;	// Control reg and SRAM read ack
	logic accept;
	logic ctrl_sel;

	// Ignore the strobe while a request is open or being acked
	assign accept   = wb_cyc & wb_stb & ~wb_ack & ~wr.wr_req;
	assign ctrl_sel = wb_adr[board_pkg::CTRL_SEL_BIT];

	always_ff @(posedge clk_sys or negedge pll_lckd) begin
		if (!pll_lckd) begin
			ctrl_ack  <= 1'b0;
			loading   <= 1'b0;
			wr.wr_req <= 1'b0;
			wb_dat_r  <= '0;
		end else begin
			ctrl_ack <= 1'b0;
			if (wr.wr_done)
				wr.wr_req <= 1'b0;
			if (accept) begin
				if (ctrl_sel) begin
					ctrl_ack <= 1'b1;
					wb_dat_r <= board_pkg::rom_data_t'(loading);
					if (wb_we)
						loading <= wb_dat_w[0];
				end else if (wb_we) begin
					wr.wr_req <= 1'b1;	// Acked on wr_done
				end else begin
					ctrl_ack <= 1'b1;	// SRAM is not readable from the host
					wb_dat_r <= '0;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept && !ctrl_sel && wb_we) begin
			wr.wr_addr <= wb_adr[board_pkg::ROM_ADDR_W-1:0];
			wr.wr_data <= wb_dat_w;
		end
	end

	assign wb_ack = ctrl_ack | wr.wr_done;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the board glue testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_board_glue \
	-f project.f \
	-o sim_board_glue

./obj_dir/sim_board_glue +verilator+error+limit+1000 | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// File: testbench/board_glue_checker.sv
//------------------------------------------------
// Board glue checker
// Reset, Wishbone, SRAM and core reset rules
//------------------------------------------------
`default_nettype none

module board_glue_checker #(
	parameter int RESET_HOLD = 256
) (
	input logic                           clk_sys,
	input logic                           pll_lckd,
	input logic                           reset_btn,
	input logic                           loading,
	input logic                           core_reset_n,
	input logic                           wb_cyc,
	input logic                           wb_stb,
	input logic                           wb_we,
	input logic [board_pkg::ROM_ADDR_W:0] wb_adr,
	input board_pkg::rom_data_t           wb_dat_w,
	input logic                           wb_ack,
	input board_pkg::rom_addr_t           rom_addr,
	input board_pkg::rom_data_t           rom_data,
	input board_pkg::rom_addr_t           sram_addr,
	input board_pkg::rom_data_t           sram_dout,
	input board_pkg::rom_data_t           sram_din,
	input logic                           sram_dout_oe,
	input logic                           sram_we_n,
	input logic                           joy_load,
	input logic                           joy_clk,
	input logic                           audio_out
);

	int fail_count = 0;
	int since_lock;	// Saturating count of edges since lock

	always_ff @(posedge clk_sys or negedge pll_lckd) begin
		if (!pll_lckd)
			since_lock <= 0;
		else if (since_lock < RESET_HOLD + 2)
			since_lock <= since_lock + 1;
	end

	//------------------------------------------------
	// Reset and core reset timing
	//------------------------------------------------
	reset_state: assert property (@(posedge clk_sys) !pll_lckd |-> sram_we_n && !sram_dout_oe
		&& !wb_ack && !core_reset_n && joy_load && !joy_clk && !audio_out)
		else begin
			fail_count++;
			$error("outputs not idle while the PLL is unlocked");
		end
	hold_low: assert property (@(posedge clk_sys) since_lock <= RESET_HOLD |-> !core_reset_n)
		else begin
			fail_count++;
			$error("core left reset before the hold count");
		end
	hold_release: assert property (@(posedge clk_sys) since_lock == RESET_HOLD + 1 |-> core_reset_n)
		else begin
			fail_count++;
			$error("core still in reset after the hold count");
		end
	core_held: assert property (@(posedge clk_sys) disable iff (!pll_lckd)
		(reset_btn || loading) |=> !core_reset_n)
		else begin
			fail_count++;
			$error("core not held by button or loading flag");
		end
	core_freed: assert property (@(posedge clk_sys) disable iff (!pll_lckd)
		(since_lock > RESET_HOLD && !reset_btn && !loading) |=> core_reset_n)
		else begin
			fail_count++;
			$error("core not released");
		end

	//------------------------------------------------
	// Wishbone and SRAM
	//------------------------------------------------
	write_pins: assert property (@(posedge clk_sys) disable iff (!pll_lckd)
		!sram_we_n |-> sram_dout_oe && wb_cyc && wb_stb && wb_we
			&& !wb_adr[board_pkg::CTRL_SEL_BIT] && sram_addr == wb_adr[board_pkg::ROM_ADDR_W-1:0]
			&& sram_dout == wb_dat_w && rom_data == '0)
		else begin
			fail_count++;
			$error("SRAM write cycle does not match the bus");
		end
	write_single: assert property (@(posedge clk_sys) disable iff (!pll_lckd)
		!sram_we_n |=> sram_we_n && wb_ack)
		else begin
			fail_count++;
			$error("write strobe not one cycle ahead of ack");
		end
	write_ack: assert property (@(posedge clk_sys) disable iff (!pll_lckd)
		$rose(wb_stb) && wb_cyc && wb_we && !wb_adr[board_pkg::CTRL_SEL_BIT]
			|-> !wb_ack ##1 !sram_we_n ##1 wb_ack)
		else begin
			fail_count++;
			$error("SRAM write ack not two cycles after strobe");
		end
	short_ack: assert property (@(posedge clk_sys) disable iff (!pll_lckd)
		$rose(wb_stb) && wb_cyc && !(wb_we && !wb_adr[board_pkg::CTRL_SEL_BIT]) |=> wb_ack)
		else begin
			fail_count++;
			$error("control or read ack not after one cycle");
		end
	ack_pulse: assert property (@(posedge clk_sys) disable iff (!pll_lckd) wb_ack |=> !wb_ack)
		else begin
			fail_count++;
			$error("ack longer than one cycle");
		end
	oe_idle: assert property (@(posedge clk_sys) disable iff (!pll_lckd)
		!(wb_cyc && wb_stb && wb_we) |-> !sram_dout_oe && sram_we_n)
		else begin
			fail_count++;
			$error("SRAM driven without a bus write");
		end
	read_path: assert property (@(posedge clk_sys) disable iff (!pll_lckd)
		sram_we_n |-> sram_addr == rom_addr && rom_data == sram_din)
		else begin
			fail_count++;
			$error("core read path not passed through");
		end

endmodule

bind board_glue_top board_glue_checker #(
	.RESET_HOLD (RESET_HOLD)
) checker_inst (.*);

`default_nettype wire

// File: testbench/tb_board_glue.sv
//------------------------------------------------
// Board glue testbench
// Wishbone host, SRAM and joystick models with
// read-back, button and audio scoreboards
//------------------------------------------------
`default_nettype none

module tb_board_glue;

	localparam int          RESET_HOLD   = 40;
	localparam int          ENA_DIV_LOG2 = 2;
	localparam int          WAIT_LIMIT   = 2000;	// Cycles per wait loop
	localparam int          RUN_LIMIT    = 100000;	// Cycles for the whole run
	localparam logic [31:0] SEED         = 32'h8de52616;
	localparam logic [19:0] CTRL_ADR     = 20'h8_0000;	// CTRL_SEL_BIT set

	logic                    clk_sys = 1'b0;
	logic                    pll_lckd;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	logic [19:0]             wb_adr;
	board_pkg::rom_data_t    wb_dat_w;
	board_pkg::rom_data_t    wb_dat_r;
	logic                    wb_ack;
	board_pkg::rom_addr_t    rom_addr;
	board_pkg::rom_data_t    rom_data;
	logic                    core_reset_n;
	board_pkg::rom_data_t    sound;
	logic                    reset_btn;
	logic                    joy_clk;
	logic                    joy_load;
	logic                    joy_data;
	board_pkg::joy_buttons_t buttons_p1;
	board_pkg::joy_buttons_t buttons_p2;
	board_pkg::rom_addr_t    sram_addr;
	board_pkg::rom_data_t    sram_dout;
	board_pkg::rom_data_t    sram_din;
	logic                    sram_dout_oe;
	logic                    sram_we_n;
	logic                    audio_out;

	int          val_errs = 0;
	int          joy_errs = 0;
	int          frames_done = 0;
	logic        timed_out = 1'b0;
	logic        stim_done = 1'b0;
	logic [31:0] lfsr;
	logic [7:0]  sram_mem [0:(1 << board_pkg::ROM_ADDR_W) - 1];
	logic [23:0] joy_sr = '1;

	always #4 clk_sys = ~clk_sys;

	board_glue_top #(
		.RESET_HOLD   (RESET_HOLD),
		.ENA_DIV_LOG2 (ENA_DIV_LOG2)
	) board_glue_top_inst (.*);

	function automatic logic [7:0] fill_byte(input logic [18:0] a);
		return a[7:0] ^ a[15:8] ^ {5'd0, a[18:16]} ^ 8'h5a;
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// Taps 32, 22, 2, 1
	endfunction

	task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] val);
		int i;
		val = '0;
		for (i = 0; i < n; i++) begin
			st  = lfsr_step(st);
			val = {val[30:0], st[0]};
		end
	endtask

	function automatic int mismatch(input string what, input int got, input int exp);
		if (got == exp)
			return 0;
		$display("ERR %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		return 1;
	endfunction

	task automatic stall(input string what);
		$display("Timeout while waiting for %s", what);
		timed_out = 1'b1;
		forever @(negedge clk_sys);
	endtask

	task automatic wait_core_reset(input logic level);
		int n;
		n = 0;
		while (core_reset_n !== level && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (core_reset_n !== level)
			stall("core_reset_n");
	endtask

	task automatic wb_transfer(input logic we, input logic [19:0] adr, input logic [7:0] dat,
			output logic [7:0] rdat);
		int n;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (!wb_ack && n < WAIT_LIMIT);
		if (!wb_ack)
			stall("Wishbone ack");
		rdat   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clk_sys);	// Bus idle for one cycle between transfers
	endtask

	task automatic wait_frames(input int count);
		int n;
		int target;
		target = frames_done + count;
		n = 0;
		while (frames_done < target && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (frames_done < target)
			stall("a joystick frame");
	endtask

	task automatic check_rom(input logic [18:0] a, input logic [7:0] exp);
		rom_addr = a;
		@(negedge clk_sys);
		val_errs += mismatch("rom_data", int'(rom_data), int'(exp));
	endtask

	task automatic check_audio(input logic [7:0] n);
		int ones;
		int i;
		sound = n;
		repeat (2) @(negedge clk_sys);	// Accumulator now adds n only
		ones = 0;
		for (i = 0; i < 256; i++) begin
			if (audio_out)
				ones++;
			@(negedge clk_sys);
		end
		val_errs += mismatch("audio ones per 256 cycles", ones, int'(n));
	endtask

	//------------------------------------------------
	// SRAM and joystick models
	//------------------------------------------------
	assign sram_din = sram_mem[sram_addr];
	assign joy_data = joy_sr[23];

	initial begin : sram_model
		logic [18:0] a;
		a = '0;
		do begin
			sram_mem[a] = fill_byte(a);
			a++;
		end while (a != '0);
		forever begin
			@(negedge clk_sys);
			if (!sram_we_n)
				sram_mem[sram_addr] = sram_dout;
		end
	end

	initial begin : joy_model
		logic [31:0]             bits;
		logic [23:0]             word;
		logic                    loaded;
		logic                    clk_q;
		logic                    load_q;
		logic [31:0]             st;
		board_pkg::joy_buttons_t exp_p1;
		board_pkg::joy_buttons_t exp_p2;
		loaded = 1'b0;
		clk_q  = 1'b0;
		load_q = 1'b1;
		st     = SEED;
		word   = '0;
		forever begin
			@(negedge clk_sys);
			if (!joy_load && load_q) begin
				// Next latch pulse means the last frame is in
				if (loaded) begin
					exp_p1 = ~word[23:12];
					exp_p2 = ~word[11:0];
					joy_errs += mismatch("buttons_p1", int'(buttons_p1), int'(exp_p1));
					joy_errs += mismatch("buttons_p2", int'(buttons_p2), int'(exp_p2));
					frames_done++;
				end
				draw_bits(st, 24, bits);
				word   = bits[23:0];
				joy_sr = bits[23:0];
				loaded = 1'b1;
			end else if (joy_clk && !clk_q) begin
				joy_sr = {joy_sr[22:0], 1'b1};
			end
			clk_q  = joy_clk;
			load_q = joy_load;
		end
	end

	//------------------------------------------------
	// Stimulus
	//------------------------------------------------
	initial begin : stimulus
		logic [31:0] bits;
		logic [18:0] addr;
		logic [7:0]  rdat;
		int          i;
		pll_lckd  = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = '0;
		rom_addr  = '0;
		sound     = '0;
		reset_btn = 1'b0;
		lfsr      = SEED;
		#1 pll_lckd = 1'b0;	// Real falling edge for the async resets
		repeat (2) @(negedge clk_sys);
		pll_lckd = 1'b1;
		wait_core_reset(1'b1);

		for (i = 0; i < 6; i++) begin
			draw_bits(lfsr, 18, bits);
			addr = {1'b0, bits[17:0]};	// Lower half stays unwritten
			check_rom(addr, fill_byte(addr));
		end

		for (i = 0; i < 4; i++) begin
			draw_bits(lfsr, 26, bits);
			addr = {1'b1, bits[25:8]};
			wb_transfer(1'b1, {1'b0, addr}, bits[7:0], rdat);
			check_rom(addr, bits[7:0]);
			wb_transfer(1'b0, {1'b0, addr}, 8'h00, rdat);
			val_errs += mismatch("Wishbone SRAM read", int'(rdat), 0);
		end

		// Loading flag and reset button both hold the core
		wb_transfer(1'b1, CTRL_ADR, 8'h01, rdat);
		@(negedge clk_sys);
		val_errs += mismatch("core_reset_n while loading", int'(core_reset_n), 0);
		wb_transfer(1'b0, CTRL_ADR, 8'h00, rdat);
		val_errs += mismatch("loading flag", int'(rdat), 1);
		wb_transfer(1'b1, CTRL_ADR, 8'h00, rdat);
		wait_core_reset(1'b1);
		reset_btn = 1'b1;
		wait_core_reset(1'b0);
		reset_btn = 1'b0;
		wait_core_reset(1'b1);

		wait_frames(3);

		for (i = 0; i < 3; i++) begin
			draw_bits(lfsr, 8, bits);
			check_audio(bits[7:0]);
		end
		stim_done = 1'b1;
	end

	initial begin : finish_run
		int asrt_errs;
		int n;
		n = 0;
		while (!stim_done && !timed_out && n < RUN_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!stim_done && !timed_out) begin
			$display("Timeout while waiting for the end of the stimulus");
			timed_out = 1'b1;
		end
		repeat (3) @(negedge clk_sys);	// Let pending assertions finish
		asrt_errs = board_glue_top_inst.checker_inst.fail_count;
		$display("Done: %0d value errors, %0d assertion failures, %0d frames, %0d timeouts",
			val_errs + joy_errs, asrt_errs, frames_done, int'(timed_out));
		if (val_errs + joy_errs + asrt_errs == 0 && !timed_out)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
